/* rtl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	typedef logic [31:0] word_t;

	// shift ops carry no variable form since the decoder picks the amount.
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_MOVZ,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_INVALID
	} alu_op_e;

	typedef enum logic [1:0] {
		CMP_EQUAL   = 2'd0,
		CMP_SMALLER = 2'd1,
		CMP_LARGER  = 2'd2
	} cmp_e;

	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_ADDIU = 6'd9;
	localparam logic [5:0] OP_SLTI  = 6'd10;
	localparam logic [5:0] OP_SLTIU = 6'd11;
	localparam logic [5:0] OP_ANDI  = 6'd12;
	localparam logic [5:0] OP_ORI   = 6'd13;
	localparam logic [5:0] OP_XORI  = 6'd14;

	localparam logic [5:0] F_SLL  = 6'd0;
	localparam logic [5:0] F_SRL  = 6'd2;
	localparam logic [5:0] F_SRA  = 6'd3;
	localparam logic [5:0] F_SLLV = 6'd4;
	localparam logic [5:0] F_SRLV = 6'd6;
	localparam logic [5:0] F_SRAV = 6'd7;
	localparam logic [5:0] F_MOVZ = 6'd10;
	localparam logic [5:0] F_ADD  = 6'd32;
	localparam logic [5:0] F_ADDU = 6'd33;
	localparam logic [5:0] F_SUB  = 6'd34;
	localparam logic [5:0] F_SUBU = 6'd35;
	localparam logic [5:0] F_AND  = 6'd36;
	localparam logic [5:0] F_OR   = 6'd37;
	localparam logic [5:0] F_XOR  = 6'd38;
	localparam logic [5:0] F_NOR  = 6'd39;
	localparam logic [5:0] F_SLT  = 6'd42;
	localparam logic [5:0] F_SLTU = 6'd43;

	localparam logic [2:0] REG_RS     = 3'd0; // word offsets on the bus.
	localparam logic [2:0] REG_RT     = 3'd1;
	localparam logic [2:0] REG_INSTR  = 3'd2;
	localparam logic [2:0] REG_RESULT = 3'd3;
	localparam logic [2:0] REG_STATUS = 3'd4;

	localparam int unsigned STAT_UCMP = 0; // lsb of the two-bit unsigned compare.
	localparam int unsigned STAT_SCMP = 2; // lsb of the two-bit signed compare.
	localparam int unsigned STAT_OVF  = 4;
	localparam int unsigned STAT_INV  = 5;

endpackage

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
	import alu_pkg::*;
(
	input  alu_op_e    op,
	input  word_t      num1,
	input  word_t      num2,
	input  logic [4:0] shamt,
	output word_t      result,
	output cmp_e       cmp_result,
	output cmp_e       sig_cmp_result,
	output logic       overflow,
	output logic       op_invalid
);

	logic [32:0] sum;
	logic [32:0] diff;

	// 33 bits wide so the carry or borrow lands in bit 32.
	assign sum  = {1'b0, num1} + {1'b0, num2};
	assign diff = {1'b0, num1} - {1'b0, num2};

	always_comb begin
		op_invalid = 1'b0;
		case (op)
			ALU_ADD:  result = sum[31:0];
			ALU_SUB:  result = diff[31:0];
			ALU_AND:  result = num1 & num2;
			ALU_OR:   result = num1 | num2;
			ALU_XOR:  result = num1 ^ num2;
			ALU_NOR:  result = ~(num1 | num2);
			ALU_SLT:  result = {31'b0, $signed(num1) < $signed(num2)};
			ALU_SLTU: result = {31'b0, num1 < num2};
			ALU_MOVZ: result = num1; // rs goes straight through.
			ALU_SLL:  result = num2 << shamt;
			ALU_SRL:  result = num2 >> shamt;
			ALU_SRA:  result = $signed(num2) >>> shamt; // fills with the sign bit.
			default: begin
				result     = '0;
				op_invalid = 1'b1;
			end
		endcase
	end

	always_comb begin
		case (op)
			ALU_ADD: overflow = sum[32];
			ALU_SUB: overflow = diff[32];
			default: overflow = 1'b0;
		endcase
	end

	always_comb begin
		if (num1 == num2) begin
			cmp_result = CMP_EQUAL;
		end else if (num1 < num2) begin
			cmp_result = CMP_SMALLER;
		end else begin
			cmp_result = CMP_LARGER;
		end
	end

	always_comb begin
		if (num1 == num2) begin
			sig_cmp_result = CMP_EQUAL;
		end else if ($signed(num1) < $signed(num2)) begin
			sig_cmp_result = CMP_SMALLER;
		end else begin
			sig_cmp_result = CMP_LARGER;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decode
	import alu_pkg::*;
(
	input  word_t      instr,
	input  word_t      rs_val,
	input  word_t      rt_val,
	output alu_op_e    op,
	output word_t      num1,
	output word_t      num2,
	output logic [4:0] shamt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	word_t      sext_imm;
	word_t      zext_imm;

	assign opcode   = instr[31:26];
	assign funct    = instr[5:0];
	assign sext_imm = {{16{instr[15]}}, instr[15:0]};
	assign zext_imm = {16'b0, instr[15:0]};

	assign num1 = rs_val;

	always_comb begin
		op    = ALU_INVALID;
		num2  = rt_val;
		shamt = instr[10:6]; // the ALU looks at this only for shifts.
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					F_SLL: op = ALU_SLL;
					F_SRL: op = ALU_SRL;
					F_SRA: op = ALU_SRA;
					F_SLLV: begin
						op    = ALU_SLL;
						shamt = rs_val[4:0];
					end
					F_SRLV: begin
						op    = ALU_SRL;
						shamt = rs_val[4:0];
					end
					F_SRAV: begin
						op    = ALU_SRA;
						shamt = rs_val[4:0];
					end
					F_MOVZ: op = ALU_MOVZ;
					F_ADD, F_ADDU: op = ALU_ADD;
					F_SUB, F_SUBU: op = ALU_SUB;
					F_AND:  op = ALU_AND;
					F_OR:   op = ALU_OR;
					F_XOR:  op = ALU_XOR;
					F_NOR:  op = ALU_NOR;
					F_SLT:  op = ALU_SLT;
					F_SLTU: op = ALU_SLTU;
					default: op = ALU_INVALID;
				endcase
			end
			OP_ADDI, OP_ADDIU: begin
				op   = ALU_ADD;
				num2 = sext_imm;
			end
			OP_SLTI: begin
				op   = ALU_SLT;
				num2 = sext_imm;
			end
			OP_SLTIU: begin
				op   = ALU_SLTU;
				num2 = sext_imm; // sign-extended but compared unsigned, as in MIPS.
			end
			OP_ANDI: begin
				op   = ALU_AND;
				num2 = zext_imm;
			end
			OP_ORI: begin
				op   = ALU_OR;
				num2 = zext_imm;
			end
			OP_XORI: begin
				op   = ALU_XOR;
				num2 = zext_imm;
			end
			default: op = ALU_INVALID;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/alu_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_wb_regs
	import alu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [2:0] wb_adr,
	input  word_t      wb_dat_w,
	input  word_t      result,
	input  cmp_e       cmp_result,
	input  cmp_e       sig_cmp_result,
	input  logic       overflow,
	input  logic       op_invalid,
	output word_t      wb_dat_r,
	output logic       wb_ack,
	output word_t      rs_val,
	output word_t      rt_val,
	output word_t      instr
);

	logic  req;
	logic  instr_wr;
	word_t instr_q;
	word_t result_q;
	word_t status_q;
	word_t status_d;
	word_t rd_data;

	// a new request is one not yet answered by ack.
	assign req      = wb_cyc && wb_stb && !wb_ack;
	assign instr_wr = req && wb_we && (wb_adr == REG_INSTR);

	// while the instruction is being written the decoder already sees it.
	// This lets RESULT load at the edge that raises ack.
	assign instr = instr_wr ? wb_dat_w : instr_q;

	always_comb begin
		status_d                 = '0;
		status_d[STAT_UCMP +: 2] = cmp_result;
		status_d[STAT_SCMP +: 2] = sig_cmp_result;
		status_d[STAT_OVF]       = overflow;
		status_d[STAT_INV]       = op_invalid;
	end

	always_comb begin
		case (wb_adr)
			REG_RS:     rd_data = rs_val;
			REG_RT:     rd_data = rt_val;
			REG_INSTR:  rd_data = instr_q;
			REG_RESULT: rd_data = result_q;
			REG_STATUS: rd_data = status_q;
			default:    rd_data = '0; // unmapped offsets read as zero.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
			rs_val   <= '0;
			rt_val   <= '0;
			instr_q  <= '0;
			result_q <= '0;
			status_q <= '0;
		end else begin
			wb_ack <= req; // exactly one cycle since req needs ack low.
			if (req && !wb_we) begin
				wb_dat_r <= rd_data;
			end
			if (req && wb_we) begin
				case (wb_adr)
					REG_RS: rs_val <= wb_dat_w;
					REG_RT: rt_val <= wb_dat_w;
					REG_INSTR: begin
						instr_q  <= wb_dat_w;
						result_q <= result;
						status_q <= status_d;
					end
					default: ; // RESULT and STATUS are read only.
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/alu_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit_top
	import alu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [4:2] wb_adr, // word address of the register.
	input  word_t      wb_dat_w,
	output word_t      wb_dat_r,
	output logic       wb_ack
);

	word_t      rs_val;
	word_t      rt_val;
	word_t      instr;
	alu_op_e    op;
	word_t      num1;
	word_t      num2;
	logic [4:0] shamt;
	word_t      result;
	cmp_e       cmp_result;
	cmp_e       sig_cmp_result;
	logic       overflow;
	logic       op_invalid;

	alu_wb_regs regs_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w),
		.result         (result),
		.cmp_result     (cmp_result),
		.sig_cmp_result (sig_cmp_result),
		.overflow       (overflow),
		.op_invalid     (op_invalid),
		.wb_dat_r       (wb_dat_r),
		.wb_ack         (wb_ack),
		.rs_val         (rs_val),
		.rt_val         (rt_val),
		.instr          (instr)
	);

	alu_decode decode_i (
		.instr  (instr),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.op     (op),
		.num1   (num1),
		.num2   (num2),
		.shamt  (shamt)
	);

	alu alu_i (
		.op             (op),
		.num1           (num1),
		.num2           (num2),
		.shamt          (shamt),
		.result         (result),
		.cmp_result     (cmp_result),
		.sig_cmp_result (sig_cmp_result),
		.overflow       (overflow),
		.op_invalid     (op_invalid)
	);

endmodule

`default_nettype wire

/* tests/alu_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit_assert (
	input logic clk,
	input logic arst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	// the reset clears ack at once, so every edge inside reset sees it low.
	ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_ack)
		else $error("wb_ack is high while arst_n is asserted");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles");

	ack_follows_request: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without cyc and stb in the previous cycle");

endmodule

bind alu_unit_top alu_unit_assert assert_i (
	.clk    (clk),
	.arst_n (arst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack)
);

`default_nettype wire

/* tests/tb_alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_unit
	import alu_pkg::*;
();

	logic       clk;
	logic       arst_n;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	logic [2:0] wb_adr;
	word_t      wb_dat_w;
	word_t      wb_dat_r;
	logic       wb_ack;

	word_t lcg_state = 32'd46309;
	string cur_test;
	int    mismatches;
	int    n_pass = 0;
	int    n_fail = 0;

	int n_arith = 200;
	int n_shift = 48;
	int n_imm   = 100;
	int n_cmp   = 60;
	int n_inv   = 30;

	logic [5:0] arith_fns [11] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
		F_SLT, F_SLTU, F_MOVZ};
	logic [5:0] shift_fns [6] = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV};
	logic [5:0] bad_fns [13] = '{6'd1, 6'd5, 6'd8, 6'd9, 6'd11, 6'd12, 6'd13, 6'd16, 6'd24,
		6'd40, 6'd41, 6'd44, 6'd63};

	alu_unit_top dut_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 16); // folds the better high bits into the low ones.
	endfunction

	// expected behavior of the unit, taken from the ISA rules.
	function automatic void model(input word_t ins, input word_t rs, input word_t rt,
			output word_t res, output cmp_e ucmp, output cmp_e scmp,
			output logic ovf, output logic inv);
		logic [5:0] opc;
		logic [5:0] fn;
		logic [4:0] sh;
		word_t      b;
		opc = ins[31:26];
		fn  = ins[5:0];
		sh  = ins[10:6];
		b   = rt;
		if (opc == OP_ADDI || opc == OP_ADDIU || opc == OP_SLTI || opc == OP_SLTIU) begin
			b = {{16{ins[15]}}, ins[15:0]};
		end else if (opc >= OP_ANDI && opc <= OP_XORI) begin
			b = {16'h0, ins[15:0]};
		end
		if (opc == OP_RTYPE && (fn == F_SLLV || fn == F_SRLV || fn == F_SRAV)) begin
			sh = rs[4:0];
		end
		ucmp = (rs == b) ? CMP_EQUAL : ((rs < b) ? CMP_SMALLER : CMP_LARGER);
		scmp = (rs == b) ? CMP_EQUAL : (($signed(rs) < $signed(b)) ? CMP_SMALLER : CMP_LARGER);
		res = '0;
		ovf = 1'b0;
		inv = 1'b0;
		if (opc == OP_RTYPE) begin
			case (fn)
				F_SLL, F_SLLV: res = b << sh;
				F_SRL, F_SRLV: res = b >> sh;
				F_SRA, F_SRAV: res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
				F_MOVZ:        res = rs;
				F_ADD, F_ADDU: begin
					res = rs + b;
					ovf = res < rs; // a wrapped sum means a carry out.
				end
				F_SUB, F_SUBU: begin
					res = rs - b;
					ovf = rs < b;
				end
				F_AND:  res = rs & b;
				F_OR:   res = rs | b;
				F_XOR:  res = rs ^ b;
				F_NOR:  res = ~(rs | b);
				F_SLT:  res = {31'b0, scmp == CMP_SMALLER};
				F_SLTU: res = {31'b0, ucmp == CMP_SMALLER};
				default: inv = 1'b1;
			endcase
		end else begin
			case (opc)
				OP_ADDI, OP_ADDIU: begin
					res = rs + b;
					ovf = res < rs;
				end
				OP_SLTI:  res = {31'b0, scmp == CMP_SMALLER};
				OP_SLTIU: res = {31'b0, ucmp == CMP_SMALLER};
				OP_ANDI:  res = rs & b;
				OP_ORI:   res = rs | b;
				OP_XORI:  res = rs ^ b;
				default:  inv = 1'b1;
			endcase
		end
	endfunction

	task automatic bus_write(input logic [2:0] adr, input word_t data);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= data;
		@(posedge clk);
		while (!wb_ack) @(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(posedge clk); // one idle cycle between requests.
	endtask

	task automatic bus_read(input logic [2:0] adr, output word_t data);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		@(posedge clk);
		while (!wb_ack) @(posedge clk);
		data = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		@(posedge clk);
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("** Error %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_cmp(input string what, input cmp_e exp, input cmp_e act);
		if (exp !== act) begin
			$display("** Error %s %s: expected %s, actual %s (%0d)", cur_test, what,
				exp.name(), act.name(), act);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test   = name;
		mismatches = 0;
	endtask

	task automatic finish_test();
		if (mismatches == 0) begin
			n_pass++;
			$display("test %s: pass", cur_test);
		end else begin
			n_fail++;
			$display("test %s: fail with %0d mismatches", cur_test, mismatches);
		end
	endtask

	task automatic run_instr(input word_t rs, input word_t rt, input word_t ins);
		word_t exp_res;
		cmp_e  exp_u;
		cmp_e  exp_s;
		logic  exp_ovf;
		logic  exp_inv;
		word_t res;
		word_t st;
		bus_write(REG_RS, rs);
		bus_write(REG_RT, rt);
		bus_write(REG_INSTR, ins);
		bus_read(REG_RESULT, res);
		bus_read(REG_STATUS, st);
		model(ins, rs, rt, exp_res, exp_u, exp_s, exp_ovf, exp_inv);
		check_word($sformatf("result of %08h", ins), exp_res, res);
		check_cmp("unsigned compare", exp_u, cmp_e'(st[STAT_UCMP +: 2]));
		check_cmp("signed compare", exp_s, cmp_e'(st[STAT_SCMP +: 2]));
		check_flag("overflow", exp_ovf, st[STAT_OVF]);
		check_flag("op_invalid", exp_inv, st[STAT_INV]);
	endtask

	task automatic test_reset_state();
		word_t got;
		start_test("reset_state");
		for (int a = 0; a < 8; a++) begin
			bus_read(3'(a), got);
			check_word($sformatf("offset %0d", a), 32'h0, got);
		end
		finish_test();
	endtask

	task automatic test_rtype_arith();
		word_t r;
		int    k;
		start_test("rtype_arith");
		for (int i = 0; i < n_arith; i++) begin
			r = next_rand();
			k = int'(r[31:28]) % 11;
			run_instr(next_rand(), next_rand(), {6'b0, r[25:6], arith_fns[k]});
		end
		finish_test();
	endtask

	task automatic test_shifts();
		word_t      r;
		word_t      rs;
		word_t      rt;
		logic [4:0] amt;
		int         k;
		start_test("shifts");
		for (int i = 0; i < n_shift; i++) begin
			r   = next_rand();
			k   = i % 6;
			amt = (i < 6) ? 5'd0 : ((i < 12) ? 5'd31 : r[4:0]); // every shift sees 0 and 31.
			rs  = next_rand();
			rt  = next_rand();
			if (k >= 3) begin
				rs[4:0] = amt;
			end
			if (i % 2 == 1) begin
				rt[31] = 1'b1;
			end
			// variable shifts get a stray shamt field that must be ignored.
			run_instr(rs, rt, {6'b0, r[25:11], (k < 3) ? amt : r[10:6], shift_fns[k]});
		end
		finish_test();
	endtask

	task automatic test_immediates();
		word_t      r;
		logic [5:0] opc;
		start_test("immediates");
		for (int i = 0; i < n_imm; i++) begin
			r   = next_rand();
			opc = 6'(OP_ADDI + (r[31:29] % 7));
			run_instr(next_rand(), next_rand(), {opc, r[25:0]});
		end
		finish_test();
	endtask

	task automatic test_compares();
		word_t rs;
		word_t rt;
		start_test("compares");
		for (int i = 0; i < n_cmp; i++) begin
			rs = next_rand();
			case (i % 3)
				0:       rt = rs;
				1:       rt = rs ^ 32'h8000_0000; // signed and unsigned orders disagree.
				default: rt = next_rand();
			endcase
			run_instr(rs, rt, {6'b0, 20'h0, (i % 2 == 0) ? F_SUBU : F_SLT});
		end
		finish_test();
	endtask

	task automatic test_invalid_ops();
		word_t      r;
		logic [5:0] opc;
		int         k;
		start_test("invalid_ops");
		for (int i = 0; i < n_inv; i++) begin
			r = next_rand();
			k = int'(r[31:28]) % 13;
			if (i % 2 == 0) begin
				run_instr(next_rand(), next_rand(), {6'b0, r[25:6], bad_fns[k]});
			end else begin
				opc = (i % 4 == 1) ? 6'(1 + (r[31:29] % 7)) : 6'(15 + (r[31:26] % 49));
				run_instr(next_rand(), next_rand(), {opc, r[25:0]});
			end
		end
		finish_test();
	endtask

	task automatic test_ignored_writes();
		word_t rs;
		word_t rt;
		word_t ins;
		word_t res0;
		word_t st0;
		word_t got;
		start_test("ignored_writes");
		rs  = next_rand();
		rt  = next_rand();
		ins = {6'b0, 20'h0, F_ADDU};
		run_instr(rs, rt, ins);
		bus_read(REG_RESULT, res0);
		bus_read(REG_STATUS, st0);
		bus_write(REG_RESULT, ~res0);
		bus_write(REG_STATUS, ~st0);
		bus_read(REG_RESULT, got);
		check_word("result after write to it", res0, got);
		bus_read(REG_STATUS, got);
		check_word("status after write to it", st0, got);
		bus_write(REG_RS, rs ^ 32'h0000_ffff);
		bus_read(REG_RESULT, got);
		check_word("result after rs write", res0, got);
		run_instr(rs ^ 32'h0000_ffff, rt, ins);
		finish_test();
	endtask

	initial begin : watchdog
		int budget;
		budget = (8 + 18 + 5 * (n_arith + n_shift + n_imm + n_cmp + n_inv)) * 4 + 10 + 200;
		repeat (budget) @(posedge clk);
		$display("timeout: the tests did not finish within %0d clock cycles", budget);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		arst_n   <= 1'b0;
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		wb_we    <= 1'b0;
		wb_adr   <= 3'd0;
		wb_dat_w <= '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		test_reset_state();
		test_rtype_arith();
		test_shifts();
		test_immediates();
		test_compares();
		test_invalid_ops();
		test_ignored_writes();
		$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/alu_pkg.sv
rtl/alu.sv
rtl/alu_decode.sv
rtl/alu_wb_regs.sv
rtl/alu_unit_top.sv
tests/alu_unit_assert.sv
tests/tb_alu_unit.sv

/* Makefile */
VERILATOR = verilator
TOP       = tb_alu_unit
FILELIST  = all.f
FLAGS     = --timing --assert --top-module $(TOP)
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
